/* all.f */
+incdir+include
src/invaders_pkg.sv
src/video_timing.sv
src/pixel_shifter.sv
src/bit_shifter.sv
src/input_ports.sv
src/sound_port.sv
src/invaders_video_io.sv
test/tb_invaders.sv

/* Makefile */
# build and run the video and i/o testbench with verilator

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f all.f --top-module tb_invaders -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_invaders 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing --assert -f all.f --top-module tb_invaders

clean:
	rm -rf obj_dir

/* include/tb_model.svh */
// reference functions for the testbench; include inside a module that imports invaders_pkg::*
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

	// next raw horizontal count
	function automatic hcount_t model_next_h(hcount_t h);
		return (h == H_LAST_VISIBLE) ? H_BLANK_START : hcount_t'(h + 9'd1);
	endfunction

	// next raw vertical count, only moves at the hblank edge
	function automatic vcount_t model_next_v(vcount_t v, hcount_t h);
		if (h != H_BLANK_START)
			return v;
		if (v == V_LAST_VISIBLE)
			return V_BLANK_START;
		if (v == V_LAST)
			return V_FIRST_VISIBLE;
		return vcount_t'(v + 9'd1);
	endfunction

	// byte address for a beam position
	function automatic vram_addr_t model_vram_addr(beam_t b, logic flip);
		pos_t row;
		row = ~b.vpos + V_FLIP_OFFSET;
		return flip ? {row, ~b.hpos[7:3]} : {b.vpos, b.hpos[7:3]};
	endfunction

	// video ram contents as a hash of the address
	function automatic byte_t model_vram_data(vram_addr_t a);
		logic [15:0] h;
		h = {3'b000, a} * 16'h9e37 + 16'h3c5a;
		return h[15:8] ^ h[7:0];
	endfunction

	// barrel shifter window of the two-byte word
	function automatic byte_t model_shift(logic [15:0] word, shift_amt_t amt);
		logic [15:0] moved;
		moved = word << amt;
		return moved[15:8];
	endfunction

	// read port layouts
	function automatic byte_t model_read_port(port_t p, controls_t c, byte_t sr);
		case (p)
			3'd0: return {1'b0, 1'b1, c.left, c.fire, 3'b000, 1'b0};
			3'd1: return {1'b0, c.right, c.left, c.fire, 1'b1, c.start, c.start, c.coin};
			3'd2: return {c.dip[4], c.right, c.left, c.fire, c.dip[3], 1'b0, c.dip[2], c.dip[0]};
			3'd3: return sr;
			default: return 8'h00;
		endcase
	endfunction

	// sixteen-bit sound frame, msb first
	function automatic logic [15:0] model_sound_frame(sound_a_t a, sound_b_t b);
		return {6'b000000, b, 1'b0, a[3:1], ~a[0]};
	endfunction

`endif

/* test/tb_invaders.sv */
// runs two whole frames from reset with random i/o; vram is a hash of the address, flip toggles once a frame
module tb_invaders import invaders_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	`include "tb_model.svh"

	// two frames are 167680 cycles, leave some margin
	localparam int CYCLE_LIMIT = 200000;

	logic clk;
	logic rst_n;
	logic flip;
	controls_t controls;
	io_write_t io_wr;
	port_t io_rd_port;
	byte_t io_rd_data;
	vram_addr_t vram_addr;
	byte_t vram_data;
	beam_t beam;
	logic pixel;
	sound_a_t sound_a;
	sound_b_t sound_b;
	logic sound_serial;
	logic sound_latch;

	// model state for the cycle in progress
	hcount_t m_h;
	vcount_t m_v;
	logic [15:0] m_word;
	shift_amt_t m_amt;
	sound_a_t m_sa;
	sound_b_t m_sb;
	// short beam and flip history for the fetch latency
	beam_t hist_beam[16];
	logic hist_flip[16];
	int cycle;
	int frames;
	logic [31:0] rng;

	invaders_video_io invaders_video_io_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.flip         (flip),
		.controls     (controls),
		.io_wr        (io_wr),
		.io_rd_port   (io_rd_port),
		.io_rd_data   (io_rd_data),
		.vram_addr    (vram_addr),
		.vram_data    (vram_data),
		.beam         (beam),
		.pixel        (pixel),
		.sound_a      (sound_a),
		.sound_b      (sound_b),
		.sound_serial (sound_serial),
		.sound_latch  (sound_latch)
	);

	// video ram answers in the same cycle
	assign vram_data = model_vram_data(vram_addr);

	always #2 clk = ~clk;

	function automatic logic [31:0] next_random(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// beam outputs decoded from the raw counts
	function automatic beam_t expected_beam(hcount_t h, vcount_t v);
		beam_t b;
		b.hpos = h[7:0];
		b.vpos = v[7:0];
		b.hblank = h[8];
		b.vblank = v[8];
		b.hsync = h[8] && !h[5] && h[4];
		b.vsync = v[8] && v[3] && v[2] && !v[4];
		return b;
	endfunction

	task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
		assert (exp === act)
		else
		begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// compare every output against the model for the cycle that just ended
	task automatic check_cycle();
		beam_t eb;
		logic [2:0] k;
		int t;
		byte_t data;
		logic exp_pix;
		vram_addr_t exp_addr;
		logic [15:0] frame;
		eb = expected_beam(m_h, m_v);
		compare_value("beam", 32'(eb), 32'(beam));
		hist_beam[4'(cycle)] = eb;
		hist_flip[4'(cycle)] = flip;
		// address of the last byte boundary, one cycle back
		exp_addr = '0;
		if (cycle > 0)
		begin
			k = hist_beam[4'(cycle - 1)].hpos[2:0];
			t = cycle - 1 - int'(k);
			exp_addr = model_vram_addr(hist_beam[4'(t)], hist_flip[4'(t)]);
		end
		compare_value("vram_addr", 32'(exp_addr), 32'(vram_addr));
		// pixel trails its beam by two cycles
		exp_pix = 1'b0;
		if (cycle >= 2)
		begin
			k = hist_beam[4'(cycle - 2)].hpos[2:0];
			t = cycle - 2 - int'(k);
			data = model_vram_data(model_vram_addr(hist_beam[4'(t)], hist_flip[4'(t)]));
			exp_pix = flip ? data[3'd7 - k] : data[k];
			if (hist_beam[4'(cycle - 2)].hblank || hist_beam[4'(cycle - 2)].vblank)
				exp_pix = 1'b0;
		end
		compare_value("pixel", 32'(exp_pix), 32'(pixel));
		compare_value("io_rd_data",
			32'(model_read_port(io_rd_port, controls, model_shift(m_word, m_amt))),
			32'(io_rd_data));
		compare_value("sound_a", 32'(m_sa), 32'(sound_a));
		compare_value("sound_b", 32'(m_sb), 32'(sound_b));
		frame = model_sound_frame(m_sa, m_sb);
		compare_value("sound_serial", 32'(frame[4'd15 - m_h[3:0]]), 32'(sound_serial));
		compare_value("sound_latch", 32'(m_h[3:0] == 4'd0), 32'(sound_latch));
	endtask

	// writes take effect at this edge, counters step
	task automatic advance_model();
		if (io_wr.strobe)
		begin
			case (io_wr.port)
				PORT_SHIFT_DATA: m_word = {io_wr.data, m_word[15:8]};
				PORT_SHIFT_AMT: m_amt = io_wr.data[2:0];
				PORT_SOUND_A: m_sa = io_wr.data[5:0];
				PORT_SOUND_B: m_sb = io_wr.data[4:0];
				default: ;
			endcase
		end
		m_v = model_next_v(m_v, m_h);
		m_h = model_next_h(m_h);
		cycle++;
		if (m_h == 9'h000 && m_v == V_FIRST_VISIBLE)
			frames++;
	endtask

	// new inputs on the falling edge
	task automatic drive_inputs();
		rng = next_random(rng);
		controls = controls_t'(rng[9:0]);
		io_rd_port = rng[12:10];
		// sparse single-cycle writes to ports 2..5
		if (!io_wr.strobe && rng[15:13] == 3'd0)
		begin
			io_wr.strobe = 1'b1;
			io_wr.port = 3'd2 + {1'b0, rng[17:16]};
			io_wr.data = rng[25:18];
		end
		else
			io_wr = '0;
		// flip changes deep in vblank so no visible pixel straddles it
		if (m_h == 9'h1d0 && m_v == 9'h1e8)
			flip = ~flip;
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		flip = 1'b0;
		controls = '0;
		io_wr = '0;
		io_rd_port = '0;
		rng = 32'd57247;
		m_h = '0;
		m_v = V_FIRST_VISIBLE;
		m_word = '0;
		m_amt = '0;
		m_sa = '0;
		m_sb = '0;
		cycle = 0;
		frames = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		drive_inputs();
		// first frame unflipped, second flipped
		while (frames < 2 && cycle < CYCLE_LIMIT)
		begin
			@(posedge clk);
			check_cycle();
			advance_model();
			@(negedge clk);
			drive_inputs();
		end
		if (frames == 2)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("timeout: beam did not complete two frames within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$fatal(1);
		end
	end

endmodule

/* src/invaders_video_io.sv */
// top of the video and i/o block; no registers here, all latency lives in the children
module invaders_video_io import invaders_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       flip,
	input  controls_t  controls,
	input  io_write_t  io_wr,
	input  port_t      io_rd_port,
	output byte_t      io_rd_data,
	output vram_addr_t vram_addr,
	input  byte_t      vram_data,
	output beam_t      beam,
	output logic       pixel,
	output sound_a_t   sound_a,
	output sound_b_t   sound_b,
	output logic       sound_serial,
	output logic       sound_latch
);

	// shifter result into the read mux
	byte_t shift_result;

	video_timing video_timing_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.beam  (beam)
	);

	pixel_shifter pixel_shifter_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.beam      (beam),
		.flip      (flip),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pixel     (pixel)
	);

	bit_shifter bit_shifter_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.io_wr        (io_wr),
		.shift_result (shift_result)
	);

	input_ports input_ports_inst (
		.io_rd_port   (io_rd_port),
		.controls     (controls),
		.shift_result (shift_result),
		.io_rd_data   (io_rd_data)
	);

	sound_port sound_port_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.io_wr        (io_wr),
		.beam         (beam),
		.sound_a      (sound_a),
		.sound_b      (sound_b),
		.sound_serial (sound_serial),
		.sound_latch  (sound_latch)
	);

endmodule

/* src/sound_port.sv */
// sound latches load on the edge after the write; the frame is serialized against hpos
module sound_port import invaders_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  io_write_t io_wr,
	input  beam_t     beam,
	output sound_a_t  sound_a,
	output sound_b_t  sound_b,
	output logic      sound_serial,
	output logic      sound_latch
);

	logic [FRAME_BITS-1:0] frame;
	logic [3:0] bit_sel;

	// first latch from port 3
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sound_a <= '0;
		else if (io_wr.strobe && io_wr.port == PORT_SOUND_A)
			sound_a <= io_wr.data[5:0];
	end

	// second latch from port 5
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sound_b <= '0;
		else if (io_wr.strobe && io_wr.port == PORT_SOUND_B)
			sound_b <= io_wr.data[4:0];
	end

	// frame layout msb first, sound_a bit 0 is sent inverted
	// bits 5 and 4 of sound_a stay off the wire
	assign frame = {6'b000000, sound_b, 1'b0, sound_a[3:1], ~sound_a[0]};

	// one frame bit per pixel, msb at hpos low nibble zero
	assign bit_sel = 4'(FRAME_BITS - 1) - beam.hpos[3:0];
	assign sound_serial = frame[bit_sel];
	// output latch strobe at the start of each frame
	assign sound_latch = (beam.hpos[3:0] == 4'd0);

endmodule

/* src/input_ports.sv */
// read ports decode combinationally; port 0 is the special-game layout and DIP4 is not read
module input_ports import invaders_pkg::*;
(
	input  port_t     io_rd_port,
	input  controls_t controls,
	input  byte_t     shift_result,
	output byte_t     io_rd_data
);

	always_comb
	begin
		case (io_rd_port)
			// fixed high in bit 6, fire and left only
			3'd0:
				io_rd_data = {1'b0, 1'b1, controls.left, controls.fire, 3'b000, 1'b0};
			// player one, start shows on both start bits
			3'd1:
				io_rd_data = {1'b0, controls.right, controls.left, controls.fire,
					1'b1, controls.start, controls.start, controls.coin};
			// dips mixed with controls, tilt held low
			3'd2:
				io_rd_data = {controls.dip[4], controls.right, controls.left,
					controls.fire, controls.dip[3], 1'b0, controls.dip[2],
					controls.dip[0]};
			PORT_SHIFT_RESULT:
				io_rd_data = shift_result;
			// ports 4..7 read as zero
			default:
				io_rd_data = '0;
		endcase
	end

endmodule

/* src/bit_shifter.sv */
// barrel shifter chip model; writes land on the edge after the strobe
module bit_shifter import invaders_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  io_write_t io_wr,
	output byte_t     shift_result
);

	logic [15:0] word;
	shift_amt_t amt;
	logic [3:0] top_bit;

	// new byte enters at the top, old top drops to the low byte
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			word <= '0;
		else if (io_wr.strobe && io_wr.port == PORT_SHIFT_DATA)
			word <= {io_wr.data, word[15:8]};
	end

	// shift amount from data bits 2..0
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			amt <= '0;
		else if (io_wr.strobe && io_wr.port == PORT_SHIFT_AMT)
			amt <= io_wr.data[2:0];
	end

	// window of eight bits ending at 15 minus the amount
	assign top_bit = 4'd15 - {1'b0, amt};
	assign shift_result = word[top_bit -: 8];

	// amount only moves on a port 2 write
	assert property (@(posedge clk) disable iff (!rst_n)
		amt != $past(amt) |-> $past(io_wr.strobe && io_wr.port == PORT_SHIFT_AMT));

endmodule

/* src/pixel_shifter.sv */
// vram answers combinationally in the cycle after the address; flip is read live each pixel
module pixel_shifter import invaders_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  beam_t      beam,
	input  logic       flip,
	output vram_addr_t vram_addr,
	input  byte_t      vram_data,
	output logic       pixel
);

	pos_t flip_row;
	logic boundary;
	logic load_q;
	byte_t shift_reg;
	logic [2:0] bit_cnt;
	logic [1:0] blank_d1;
	logic [1:0] blank_d2;

	// flipped row, wraps modulo 256
	assign flip_row = ~beam.vpos + V_FLIP_OFFSET;
	// a new byte every eight pixels
	assign boundary = (beam.hpos[2:0] == 3'd0);

	// byte address latched at the boundary
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			vram_addr <= '0;
			load_q <= 1'b0;
		end
		else
		begin
			load_q <= boundary;
			if (boundary)
			begin
				if (flip)
					vram_addr <= {flip_row, ~beam.hpos[7:3]};
				else
					vram_addr <= {beam.vpos, beam.hpos[7:3]};
			end
		end
	end

	// fetched byte captured one cycle after the address
	always_ff @(posedge clk)
	begin
		if (load_q)
			shift_reg <= vram_data;
	end

	// bit index restarts with each load
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (load_q)
			bit_cnt <= '0;
		else
			bit_cnt <= bit_cnt + 3'd1;
	end

	// blank pair delayed two stages to line up with the shifted bit
	// starts out blanked so the output is quiet until the first load
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			blank_d1 <= 2'b11;
			blank_d2 <= 2'b11;
		end
		else
		begin
			blank_d1 <= {beam.hblank, beam.vblank};
			blank_d2 <= blank_d1;
		end
	end

	// flipped screen sends msb first
	assign pixel = shift_reg[bit_cnt ^ {3{flip}}] & ~blank_d2[1] & ~blank_d2[0];

	// beam steps by one, so a load lands on the second pixel of each byte and nowhere else
	assert property (@(posedge clk) disable iff (!rst_n)
		load_q == (beam.hpos[2:0] == 3'd1));

endmodule

/* src/video_timing.sv */
// beam counters run one step per pixel clock; vcount only advances at the start of hblank
module video_timing import invaders_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	output beam_t beam
);

	hcount_t hcount;
	vcount_t vcount;

	// horizontal skips from end of visible to start of blank, wraps at 1ff
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hcount <= '0;
		else if (hcount == H_LAST_VISIBLE)
			hcount <= H_BLANK_START;
		else
			hcount <= hcount + 9'd1;
	end

	// vertical steps once per line, at the hblank edge
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vcount <= V_FIRST_VISIBLE;
		else if (hcount == H_BLANK_START)
		begin
			if (vcount == V_LAST_VISIBLE)
				vcount <= V_BLANK_START;
			else if (vcount == V_LAST)
				vcount <= V_FIRST_VISIBLE;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// position is the low byte, blank is bit 8
	assign beam.hpos = hcount[7:0];
	assign beam.vpos = vcount[7:0];
	assign beam.hblank = hcount[8];
	assign beam.vblank = vcount[8];
	// sync decodes from the board gates
	assign beam.hsync = hcount[8] & ~hcount[5] & hcount[4];
	assign beam.vsync = vcount[8] & vcount[3] & vcount[2] & ~vcount[4];

	// vcount stays within its two legal runs
	assert property (@(posedge clk) disable iff (!rst_n)
		vcount inside {[V_FIRST_VISIBLE:V_LAST_VISIBLE], [V_BLANK_START:V_LAST]});

endmodule

/* src/invaders_pkg.sv */
// shared types and constants for the video and i/o block; counters are raw 9-bit board values
package invaders_pkg;

	// raw beam counters, bit 8 is the blank flag
	typedef logic [8:0] hcount_t;
	typedef logic [8:0] vcount_t;

	// visible position and memory widths
	typedef logic [7:0] pos_t;
	typedef logic [12:0] vram_addr_t;
	typedef logic [7:0] byte_t;
	typedef logic [2:0] port_t;
	typedef logic [2:0] shift_amt_t;

	// sound latch widths
	typedef logic [5:0] sound_a_t;
	typedef logic [4:0] sound_b_t;

	typedef struct packed {
		pos_t hpos;
		pos_t vpos;
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
	} beam_t;

	typedef struct packed {
		logic  strobe;
		port_t port;
		byte_t data;
	} io_write_t;

	// active high controls, dip[0] is DIP3 up to dip[4] as DIP7
	typedef struct packed {
		logic       left;
		logic       right;
		logic       fire;
		logic       start;
		logic       coin;
		logic [4:0] dip;
	} controls_t;

	// horizontal sequence 000..0ff then 1c0..1ff
	localparam hcount_t H_LAST_VISIBLE = 9'h0ff;
	localparam hcount_t H_BLANK_START = 9'h1c0;

	// vertical sequence 020..0ff then 1da..1ff
	localparam vcount_t V_FIRST_VISIBLE = 9'h020;
	localparam vcount_t V_LAST_VISIBLE = 9'h0ff;
	localparam vcount_t V_BLANK_START = 9'h1da;
	localparam vcount_t V_LAST = 9'h1ff;
	// row offset for the flipped screen, applied modulo 256
	localparam pos_t V_FLIP_OFFSET = 8'h20;

	// i/o port numbers, port 3 is read and write with different meaning
	localparam port_t PORT_SHIFT_AMT = 3'd2;
	localparam port_t PORT_SHIFT_RESULT = 3'd3;
	localparam port_t PORT_SOUND_A = 3'd3;
	localparam port_t PORT_SHIFT_DATA = 3'd4;
	localparam port_t PORT_SOUND_B = 3'd5;

	// sound serial frame length in pixel clocks
	localparam int FRAME_BITS = 16;

endpackage
